// ==== cache_top.f ====
src/cache_pkg.sv
src/cache_way.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/cache_checker.sv
testbench/mem_model.sv
testbench/cache_tb.sv

// ==== testbench/cache_tests.txt ====
# op (0 read, 1 write), byte address, byte mask, write data, expected read data
# unwritten memory words read as the inverted word address
0 00001020 0 00000000 ffffefdf
0 00001028 0 00000000 ffffefd7
1 00001024 3 aabbccdd 00000000
0 00001024 0 00000000 ffffccdd
1 00002044 c 11223344 00000000
0 00002044 0 00000000 1122dfbb
# set 2 filled past two ways, evictions follow
0 00003020 0 00000000 ffffcfdf
0 0000402c 0 00000000 ffffbfd3
0 00005020 0 00000000 ffffafdf
0 00001024 0 00000000 ffffccdd
1 00001020 f deadbeef 00000000
1 00006028 1 000000a5 00000000
0 00007020 0 00000000 ffff8fdf
0 00006028 0 00000000 ffff9fa5
0 00008020 0 00000000 ffff7fdf
0 00001020 0 00000000 deadbeef
# set 4 untouched by the evictions
0 00002040 0 00000000 ffffdfbf

// ==== testbench/cache_tb.sv ====
module cache_tb;

    localparam int LIMIT = 200;    // cycles allowed for one wait

    logic               clk;
    logic               reset;
    logic               valid;
    logic               op;
    cache_pkg::tag_t    tag;
    cache_pkg::index_t  index;
    cache_pkg::offset_t offset;
    cache_pkg::strb_t   wstrb;
    cache_pkg::word_t   wdata;
    logic               addr_ok;
    logic               data_ok;
    cache_pkg::word_t   rdata;
    logic               rd_req, rd_rdy, ret_valid, ret_last;
    cache_pkg::addr_t   rd_addr;
    cache_pkg::word_t   ret_data;
    logic               wr_req, wr_rdy;
    cache_pkg::addr_t   wr_addr;
    cache_pkg::line_t   wr_data;
    logic               stall;
    int                 rd_count, wr_count, wb_errors;
    cache_pkg::addr_t   last_rd_addr, last_wr_addr;

    // tag state per set and way, for hit and victim prediction
    cache_pkg::tag_t    m_tag   [cache_pkg::SETS][2];
    logic               m_valid [cache_pkg::SETS][2];
    logic               m_dirty [cache_pkg::SETS][2];
    bit                 victim_seq [7] = '{1, 1, 0, 0, 1, 0, 1};  // way per refill after reset
    int                 misses;
    int                 errors;
    int                 tests;
    int                 total;
    logic               timed_out;

    cache_top dut_i (.*);

    mem_model mem_i (
        .clk(clk), .reset(reset), .stall(stall),
        .store(valid && addr_ok && op), .store_addr({tag, index, offset}),
        .store_strb(wstrb), .store_data(wdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy),
        .rd_count(rd_count), .wr_count(wr_count), .last_rd_addr(last_rd_addr),
        .last_wr_addr(last_wr_addr), .wb_errors(wb_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic note_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    // returns on the edge where addr_ok is seen high
    task automatic wait_addr_ok();
        int n;
        n = 0;
        @(posedge clk);
        while (!addr_ok && !timed_out) begin
            if (n == LIMIT) begin
                $display("timeout at %0t: addr_ok stayed low for %0d cycles", $time, LIMIT);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic wait_data_ok(output int lat);
        lat = 1;
        @(posedge clk);
        while (!data_ok && !timed_out) begin
            if (lat > LIMIT) begin
                $display("timeout at %0t: no data_ok within %0d cycles", $time, LIMIT);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                lat++;
            end
        end
    endtask

    task automatic run_request(input logic w, input cache_pkg::addr_t a,
                               input cache_pkg::strb_t s, input cache_pkg::word_t d,
                               input cache_pkg::word_t expect_rd);
        cache_pkg::tag_t   t;
        cache_pkg::index_t set;
        cache_pkg::addr_t  wb_addr;
        cache_pkg::word_t  got;
        int                hit_way;
        int                vic;
        int                lat, rd0, wr0, e0;
        logic              wb;
        t = a[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
        set = a[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
        hit_way = -1;
        wb = 1'b0;
        wb_addr = '0;
        lat = 0;
        got = '0;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[set][i] && m_tag[set][i] == t) begin
                hit_way = i;
            end
        end
        if (hit_way < 0) begin
            vic = victim_seq[misses % 7];
            wb = m_valid[set][vic] && m_dirty[set][vic];
            wb_addr = {m_tag[set][vic], set, {cache_pkg::OFFSET_W{1'b0}}};
            misses++;
            m_tag[set][vic] = t;
            m_valid[set][vic] = 1'b1;
            m_dirty[set][vic] = w;    // write miss leaves the line dirty
        end else if (w) begin
            m_dirty[set][hit_way] = 1'b1;
        end

        e0 = errors;
        rd0 = rd_count;
        wr0 = wr_count;
        valid = 1'b1;
        op = w;
        {tag, index, offset} = a;
        wstrb = s;
        wdata = d;
        wait_addr_ok();
        #1 valid = 1'b0;
        if (!timed_out) begin
            wait_data_ok(lat);
            got = rdata;
        end
        if (!timed_out) begin
            wait_addr_ok();    // miss finished, bus counts settled
        end
        if (!timed_out) begin
            if (!w && got != expect_rd) begin
                note_mismatch($sformatf("read %h gave %h, expected %h", a, got, expect_rd));
            end
            if ((hit_way >= 0 || w) && lat != 1) begin
                note_mismatch($sformatf("data_ok %0d cycles after acceptance", lat));
            end
            if (rd_count - rd0 != ((hit_way < 0) ? 1 : 0)) begin
                note_mismatch($sformatf("%0d line reads for %h", rd_count - rd0, a));
            end
            if (hit_way < 0 && last_rd_addr != {t, set, 4'h0}) begin
                note_mismatch($sformatf("rd_addr %h for request %h", last_rd_addr, a));
            end
            if (wr_count - wr0 != (wb ? 1 : 0)) begin
                note_mismatch($sformatf("%0d write-backs, expected %0d", wr_count - wr0, wb));
            end
            if (wb && last_wr_addr != wb_addr) begin
                note_mismatch($sformatf("wr_addr %h, expected %h", last_wr_addr, wb_addr));
            end
        end
        tests++;
        $display("test %0d %s %h stall %0d %s", tests, w ? "write" : "read", a, stall,
                 (errors == e0 && !timed_out) ? "ok" : "bad");
        #1;
    endtask

    task automatic run_file(input logic stalls);
        int               fd;
        int               w;
        string            line;
        cache_pkg::addr_t a;
        cache_pkg::strb_t s;
        cache_pkg::word_t d;
        cache_pkg::word_t e;
        stall = stalls;
        misses = 0;
        for (int i = 0; i < cache_pkg::SETS; i++) begin
            m_valid[i] = '{1'b0, 1'b0};
            m_dirty[i] = '{1'b0, 1'b0};
        end
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        if (!addr_ok || data_ok || rd_req || wr_req) begin
            note_mismatch($sformatf("after reset addr_ok %b data_ok %b rd_req %b wr_req %b",
                                    addr_ok, data_ok, rd_req, wr_req));
        end
        fd = $fopen("testbench/cache_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/cache_tests.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if ($sscanf(line, "%d %h %h %h %h", w, a, s, d, e) == 5) begin
                    run_request(w[0], a, s, d, e);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        reset = 1'b1;
        valid = 1'b0;
        op = 1'b0;
        tag = '0;
        index = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        stall = 1'b0;
        errors = 0;
        tests = 0;
        timed_out = 1'b0;
        run_file(1'b0);
        if (!timed_out) begin
            run_file(1'b1);    // same file again under random stalls
        end
        total = errors + wb_errors + dut_i.ctrl_i.checker_i.errors;
        $display("%0d tests run, %0d errors, timeout %0d", tests, total, timed_out);
        if (total == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/mem_model.sv ====
module mem_model (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,        // random ready and gaps when set
    input  logic             store,        // CPU write accepted this cycle
    input  cache_pkg::addr_t store_addr,
    input  cache_pkg::strb_t store_strb,
    input  cache_pkg::word_t store_data,
    input  logic             rd_req,
    input  cache_pkg::addr_t rd_addr,
    output logic             rd_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output cache_pkg::word_t ret_data,
    input  logic             wr_req,
    input  cache_pkg::addr_t wr_addr,
    input  cache_pkg::line_t wr_data,
    output logic             wr_rdy,
    output int               rd_count,
    output int               wr_count,
    output cache_pkg::addr_t last_rd_addr,
    output cache_pkg::addr_t last_wr_addr,
    output int               wb_errors
);

    cache_pkg::word_t mem    [cache_pkg::addr_t];   // written-back words
    cache_pkg::word_t shadow [cache_pkg::addr_t];   // memory as the CPU sees it
    cache_pkg::addr_t line_addr;
    int               beat;                         // 4 when no refill is running
    integer           seed;

    initial begin
        cache_pkg::addr_t a;
        cache_pkg::word_t w;
        seed = 38;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        line_addr = '0;
        beat = 4;
        rd_count = 0;
        wr_count = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        wb_errors = 0;
        forever begin
            @(posedge clk);
            if (reset) begin
                mem.delete();
                shadow.delete();
                rd_count = 0;
                wr_count = 0;
                beat = 4;
            end else begin
                if (store) begin
                    a = {store_addr[cache_pkg::ADDR_W-1:2], 2'b00};
                    w = shadow.exists(a) ? shadow[a] : ~a;
                    for (int i = 0; i < 4; i++) begin
                        if (store_strb[i]) begin
                            w[i*8 +: 8] = store_data[i*8 +: 8];
                        end
                    end
                    shadow[a] = w;
                end
                if (ret_valid) begin
                    beat++;
                end
                if (rd_req && rd_rdy) begin
                    line_addr = rd_addr;
                    last_rd_addr = rd_addr;
                    beat = 0;
                    rd_count++;
                end
                if (wr_req && wr_rdy) begin
                    last_wr_addr = wr_addr;
                    wr_count++;
                    for (int i = 0; i < cache_pkg::BANKS; i++) begin
                        a = wr_addr + 4 * i;
                        w = shadow.exists(a) ? shadow[a] : ~a;
                        if (wr_data[i*32 +: 32] != w) begin
                            $display("mismatch at %0t: write-back word %h is %h, expected %h",
                                     $time, a, wr_data[i*32 +: 32], w);
                            wb_errors++;
                        end
                        mem[a] = wr_data[i*32 +: 32];
                    end
                end
            end
            #1;
            rd_rdy = rd_req && (!stall || ($random(seed) & 3) != 0);
            wr_rdy = wr_req && (!stall || ($random(seed) & 3) != 0);
            ret_valid = (beat < 4) && (!stall || ($random(seed) & 1) != 0);
            ret_last = ret_valid && (beat == 3);
            a = line_addr + 4 * beat;
            ret_data = ret_valid ? (mem.exists(a) ? mem[a] : ~a) : '0;   // never written: ~address
        end
    end

endmodule

// ==== testbench/cache_checker.sv ====
module cache_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    rd_req,
    input logic                    rd_rdy,
    input cache_pkg::addr_t        rd_addr,
    input logic                    wr_req,
    input logic                    wr_rdy,
    input cache_pkg::addr_t        wr_addr,
    input cache_pkg::line_t        wr_data,
    input logic                    data_ok,
    input cache_pkg::cache_state_t state
);

    int errors = 0;    // read by the testbench at the end

    one_bus_req: assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req))
        else begin
            $error("rd_req and wr_req high together");
            errors++;
        end

    rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            $error("read request dropped or changed before rd_rdy");
            errors++;
        end

    wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            $error("write request dropped or changed before wr_rdy");
            errors++;
        end

    no_data_in_idle: assert property (@(posedge clk) disable iff (reset)
        !(data_ok && state == cache_pkg::IDLE))
        else begin
            $error("data_ok raised in IDLE");
            errors++;
        end

endmodule

bind cache_ctrl cache_checker checker_i (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_addr (rd_addr),
    .wr_req  (wr_req),
    .wr_rdy  (wr_rdy),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .data_ok (data_ok),
    .state   (state)
);

// ==== src/cache_top.sv ====
module cache_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               valid,
    input  logic               op,
    input  cache_pkg::tag_t    tag,
    input  cache_pkg::index_t  index,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::strb_t   wstrb,
    input  cache_pkg::word_t   wdata,
    output logic               addr_ok,
    output logic               data_ok,
    output cache_pkg::word_t   rdata,

    output logic               rd_req,
    output cache_pkg::addr_t   rd_addr,
    input  logic               rd_rdy,
    input  logic               ret_valid,
    input  logic               ret_last,
    input  cache_pkg::word_t   ret_data,

    output logic               wr_req,
    output cache_pkg::addr_t   wr_addr,
    output cache_pkg::line_t   wr_data,
    input  logic               wr_rdy
);

    // shared by both ways
    cache_pkg::index_t     way_index;
    cache_pkg::line_t      way_line_wdata;
    cache_pkg::tag_t       way_tag_wdata;

    cache_pkg::line_strb_t way0_line_we,     way1_line_we;
    logic                  way0_tag_we,      way1_tag_we;
    logic                  way0_dirty_set,   way1_dirty_set;
    logic                  way0_dirty_clear, way1_dirty_clear;

    cache_pkg::tag_t       way0_tag,         way1_tag;
    logic                  way0_valid,       way1_valid;
    logic                  way0_dirty,       way1_dirty;
    cache_pkg::line_t      way0_line,        way1_line;

    cache_ctrl ctrl_i (
        .clk              (clk),
        .reset            (reset),
        .valid            (valid),
        .op               (op),
        .tag              (tag),
        .index            (index),
        .offset           (offset),
        .wstrb            (wstrb),
        .wdata            (wdata),
        .addr_ok          (addr_ok),
        .data_ok          (data_ok),
        .rdata            (rdata),
        .rd_req           (rd_req),
        .rd_addr          (rd_addr),
        .rd_rdy           (rd_rdy),
        .ret_valid        (ret_valid),
        .ret_last         (ret_last),
        .ret_data         (ret_data),
        .wr_req           (wr_req),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .wr_rdy           (wr_rdy),
        .way_index        (way_index),
        .way0_line_we     (way0_line_we),
        .way1_line_we     (way1_line_we),
        .way_line_wdata   (way_line_wdata),
        .way0_tag_we      (way0_tag_we),
        .way1_tag_we      (way1_tag_we),
        .way_tag_wdata    (way_tag_wdata),
        .way0_dirty_set   (way0_dirty_set),
        .way1_dirty_set   (way1_dirty_set),
        .way0_dirty_clear (way0_dirty_clear),
        .way1_dirty_clear (way1_dirty_clear),
        .way0_tag         (way0_tag),
        .way1_tag         (way1_tag),
        .way0_valid       (way0_valid),
        .way1_valid       (way1_valid),
        .way0_dirty       (way0_dirty),
        .way1_dirty       (way1_dirty),
        .way0_line        (way0_line),
        .way1_line        (way1_line)
    );

    cache_way way0_i (
        .clk         (clk),
        .reset       (reset),
        .index       (way_index),
        .line_we     (way0_line_we),
        .line_wdata  (way_line_wdata),
        .tag_we      (way0_tag_we),
        .tag_wdata   (way_tag_wdata),
        .dirty_set   (way0_dirty_set),
        .dirty_clear (way0_dirty_clear),
        .tag_q       (way0_tag),
        .valid_q     (way0_valid),
        .dirty_q     (way0_dirty),
        .line_q      (way0_line)
    );

    cache_way way1_i (
        .clk         (clk),
        .reset       (reset),
        .index       (way_index),
        .line_we     (way1_line_we),
        .line_wdata  (way_line_wdata),
        .tag_we      (way1_tag_we),
        .tag_wdata   (way_tag_wdata),
        .dirty_set   (way1_dirty_set),
        .dirty_clear (way1_dirty_clear),
        .tag_q       (way1_tag),
        .valid_q     (way1_valid),
        .dirty_q     (way1_dirty),
        .line_q      (way1_line)
    );

endmodule

// ==== src/cache_ctrl.sv ====
module cache_ctrl (
    input  logic                  clk,
    input  logic                  reset,

    // CPU request
    input  logic                  valid,
    input  logic                  op,          // 0 read, 1 write
    input  cache_pkg::tag_t       tag,
    input  cache_pkg::index_t     index,
    input  cache_pkg::offset_t    offset,
    input  cache_pkg::strb_t      wstrb,
    input  cache_pkg::word_t      wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output cache_pkg::word_t      rdata,

    // read bus
    output logic                  rd_req,
    output cache_pkg::addr_t      rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  cache_pkg::word_t      ret_data,

    // write bus
    output logic                  wr_req,
    output cache_pkg::addr_t      wr_addr,
    output cache_pkg::line_t      wr_data,
    input  logic                  wr_rdy,

    // way control
    output cache_pkg::index_t     way_index,
    output cache_pkg::line_strb_t way0_line_we,
    output cache_pkg::line_strb_t way1_line_we,
    output cache_pkg::line_t      way_line_wdata,
    output logic                  way0_tag_we,
    output logic                  way1_tag_we,
    output cache_pkg::tag_t       way_tag_wdata,
    output logic                  way0_dirty_set,
    output logic                  way1_dirty_set,
    output logic                  way0_dirty_clear,
    output logic                  way1_dirty_clear,

    // way read data, one cycle behind way_index
    input  cache_pkg::tag_t       way0_tag,
    input  cache_pkg::tag_t       way1_tag,
    input  logic                  way0_valid,
    input  logic                  way1_valid,
    input  logic                  way0_dirty,
    input  logic                  way1_dirty,
    input  cache_pkg::line_t      way0_line,
    input  cache_pkg::line_t      way1_line
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    // request buffer
    logic                    req_op;
    cache_pkg::tag_t         req_tag;
    cache_pkg::index_t       req_index;
    cache_pkg::bank_t        req_bank;
    cache_pkg::strb_t        req_wstrb;
    cache_pkg::word_t        req_wdata;

    cache_pkg::bank_t        refill_cnt;   // next word expected from memory
    logic [2:0]              lfsr;

    logic                    accept;
    logic                    way0_hit;
    logic                    way1_hit;
    logic                    cache_hit;
    logic                    hit_write;
    logic                    refill_wr;
    logic                    refill_done;
    logic                    victim;
    logic                    victim_dirty;
    cache_pkg::tag_t         victim_tag;
    cache_pkg::word_t        hit_word;
    cache_pkg::word_t        merge_word;
    cache_pkg::word_t        refill_word;
    cache_pkg::line_strb_t   store_we;
    cache_pkg::line_strb_t   refill_we;

    assign accept = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE: begin
                if (accept) begin
                    state_next = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::LOOKUP: begin
                state_next = cache_hit ? cache_pkg::IDLE : cache_pkg::MISS;
            end
            cache_pkg::MISS: begin
                if (!victim_dirty || wr_rdy) begin   // clean victim skips the write-back
                    state_next = cache_pkg::REPLACE;
                end
            end
            cache_pkg::REPLACE: begin
                if (rd_rdy) begin
                    state_next = cache_pkg::REFILL;
                end
            end
            cache_pkg::REFILL: begin
                if (ret_valid && ret_last) begin
                    state_next = cache_pkg::IDLE;
                end
            end
            default: state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_tag   <= tag;
            req_index <= index;
            req_bank  <= offset[cache_pkg::OFFSET_W-1:2];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // new set goes to the ways while idle, else hold the buffered one
    assign way_index = (state == cache_pkg::IDLE) ? index : req_index;

    // tag compare
    assign way0_hit  = way0_valid && (way0_tag == req_tag);
    assign way1_hit  = way1_valid && (way1_tag == req_tag);
    assign cache_hit = way0_hit || way1_hit;

    assign hit_word = way1_hit ? way1_line[req_bank*32 +: 32] : way0_line[req_bank*32 +: 32];

    // victim choice
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 3'b111;
        end else if (refill_done) begin
            lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    assign victim       = lfsr[0];
    assign victim_tag   = victim ? way1_tag : way0_tag;
    assign victim_dirty = victim ? (way1_valid && way1_dirty) : (way0_valid && way0_dirty);

    // refill word count
    assign refill_wr   = (state == cache_pkg::REFILL) && ret_valid;
    assign refill_done = refill_wr && ret_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_cnt <= '0;
        end else if (refill_wr) begin
            refill_cnt <= refill_cnt + 1'b1;    // wraps to 0 after the last word
        end
    end

    // store bytes over the returned word
    always_comb begin
        merge_word = ret_data;
        for (int i = 0; i < 4; i++) begin
            if (req_wstrb[i]) begin
                merge_word[i*8 +: 8] = req_wdata[i*8 +: 8];
            end
        end
    end

    assign refill_word = (req_op && (refill_cnt == req_bank)) ? merge_word : ret_data;

    // data bank writes
    assign hit_write = (state == cache_pkg::LOOKUP) && req_op && cache_hit;
    assign store_we  = cache_pkg::line_strb_t'(req_wstrb) << (req_bank * 4);
    assign refill_we = cache_pkg::line_strb_t'(4'hf) << (refill_cnt * 4);

    always_comb begin
        way0_line_we = '0;
        way1_line_we = '0;
        if (hit_write) begin
            if (way1_hit) begin
                way1_line_we = store_we;
            end else begin
                way0_line_we = store_we;
            end
        end else if (refill_wr) begin
            if (victim) begin
                way1_line_we = refill_we;
            end else begin
                way0_line_we = refill_we;
            end
        end
    end

    // each word sits on every bank lane, the enables pick one
    assign way_line_wdata = (state == cache_pkg::REFILL) ? {cache_pkg::BANKS{refill_word}}
                                                         : {cache_pkg::BANKS{req_wdata}};

    // tag and dirty, written with the last refill word
    assign way_tag_wdata    = req_tag;
    assign way0_tag_we      = refill_done && !victim;
    assign way1_tag_we      = refill_done && victim;
    assign way0_dirty_set   = (hit_write && way0_hit) || (way0_tag_we && req_op);
    assign way1_dirty_set   = (hit_write && way1_hit) || (way1_tag_we && req_op);
    assign way0_dirty_clear = way0_tag_we && !req_op;
    assign way1_dirty_clear = way1_tag_we && !req_op;

    // CPU side
    assign addr_ok = (state == cache_pkg::IDLE);
    assign data_ok = ((state == cache_pkg::LOOKUP) && (cache_hit || req_op))
                   || (refill_wr && !req_op && (refill_cnt == req_bank));
    assign rdata   = (state == cache_pkg::REFILL) ? ret_data : hit_word;

    // bus side
    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};    // line address

    assign wr_req  = (state == cache_pkg::MISS) && victim_dirty;
    assign wr_addr = {victim_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = victim ? way1_line : way0_line;

endmodule

// ==== src/cache_way.sv ====
module cache_way (
    input  logic                  clk,
    input  logic                  reset,

    input  cache_pkg::index_t     index,       // set to read, and to write this edge

    input  cache_pkg::line_strb_t line_we,
    input  cache_pkg::line_t      line_wdata,

    input  logic                  tag_we,      // also marks the line valid
    input  cache_pkg::tag_t       tag_wdata,

    input  logic                  dirty_set,
    input  logic                  dirty_clear,

    output cache_pkg::tag_t       tag_q,
    output logic                  valid_q,
    output logic                  dirty_q,
    output cache_pkg::line_t      line_q
);

    cache_pkg::tag_t            tag_mem [cache_pkg::SETS];
    logic [cache_pkg::SETS-1:0] valid_bits;
    logic [cache_pkg::SETS-1:0] dirty_bits;

    // tag array
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[index] <= tag_wdata;
        end
        tag_q <= tag_mem[index];    // old tag when written on the same edge
    end

    // valid bits, only ever set by a refill
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_bits[index] <= 1'b1;
            end
            valid_q <= valid_bits[index];
        end
    end

    // dirty bits
    // set wins if both arrive together
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty_bits <= '0;
            dirty_q    <= 1'b0;
        end else begin
            if (dirty_set) begin
                dirty_bits[index] <= 1'b1;
            end else if (dirty_clear) begin
                dirty_bits[index] <= 1'b0;
            end
            dirty_q <= dirty_bits[index];
        end
    end

    // data banks, one word wide each with byte enables
    genvar b;
    generate
        for (b = 0; b < cache_pkg::BANKS; b++) begin : g_bank
            cache_pkg::word_t bank_mem [cache_pkg::SETS];
            cache_pkg::word_t rd_word;

            always_ff @(posedge clk) begin
                for (int y = 0; y < 4; y++) begin
                    if (line_we[b*4 + y]) begin
                        bank_mem[index][y*8 +: 8] <= line_wdata[b*32 + y*8 +: 8];
                    end
                end
                rd_word <= bank_mem[index];     // read before write
            end

            assign line_q[b*32 +: 32] = rd_word;
        end
    endgenerate

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

    // address split: tag | index | offset
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;    // 16-byte line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    localparam int SETS     = 1 << INDEX_W;
    localparam int BANKS    = 4;    // words per line

    // byte address as seen on the bus
    typedef logic [ADDR_W-1:0]   addr_t;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // word select within a line
    typedef logic [OFFSET_W-3:0] bank_t;

    typedef logic [31:0]         word_t;
    typedef logic [3:0]          strb_t;

    // bank 0 in the low bits
    typedef logic [BANKS*32-1:0] line_t;
    typedef logic [BANKS*4-1:0]  line_strb_t;   // one enable per byte of the line

    // controller states
    // IDLE     waiting for a request, addr_ok high
    // LOOKUP   tag compare on both ways
    // MISS     write back a dirty victim
    // REPLACE  line read request to memory
    // REFILL   words coming back from memory
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } cache_state_t;

endpackage
